/* build.f */
source/audio_pkg.sv
source/spi_byte_engine.sv
source/sd_block_reader.sv
source/sample_fifo.sv
source/stream_control.sv
source/audio_pwm.sv
source/audio_player.sv
verification/sd_card_model.sv
verification/tb_audio_player.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_audio_player \
    -f build.f -o tb_audio_player
./obj_dir/tb_audio_player > sim.log
cat sim.log
if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* source/audio_pkg.sv */
package audio_pkg;

    // SD block geometry
    localparam int block_bytes = 512;

    // one audio sample, unsigned
    localparam int sample_width = 8;

    // command index bytes with start and transmission bits already set
    localparam logic [7:0] cmd_go_idle = 8'h40;     // CMD0
    localparam logic [7:0] cmd_read_block = 8'h51;  // CMD17

    // data start token before the payload of a single block read
    localparam logic [7:0] token_start_block = 8'hFE;

    // R1 with only the idle bit set
    localparam logic [7:0] r1_idle = 8'h01;

    localparam int block_addr_width = 32;

endpackage

/* source/audio_player.sv */
module audio_player #(
    parameter logic [audio_pkg::block_addr_width-1:0] start_block = '0,
    parameter int fifo_depth_log2 = 10,
    parameter int spi_div = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic play,
    input  logic sd_miso,
    output logic sd_cs,
    output logic sd_sclk,
    output logic sd_mosi,
    output logic pwm_out
);

    logic                                   read_req;
    logic [audio_pkg::block_addr_width-1:0] block_addr;
    logic                                   reader_ready;
    logic                                   byte_valid;
    logic [audio_pkg::sample_width-1:0]     byte_data;
    logic                                   block_done;
    logic [audio_pkg::sample_width-1:0]     fifo_dout;
    logic                                   fifo_empty;
    logic [fifo_depth_log2:0]               fifo_count;
    logic                                   pop;
    logic                                   load_sample;
    logic                                   load_zero;
    logic                                   period_wrap;

    sd_block_reader #(
        .spi_div(spi_div)
    ) u_reader (
        .clk(clk), .reset(reset),
        .read_req(read_req), .block_addr(block_addr), .reader_ready(reader_ready),
        .byte_valid(byte_valid), .byte_data(byte_data), .block_done(block_done),
        .sd_cs(sd_cs), .sd_sclk(sd_sclk), .sd_mosi(sd_mosi), .sd_miso(sd_miso)
    );

    sample_fifo #(
        .depth_log2(fifo_depth_log2)
    ) u_fifo (
        .clk(clk), .reset(reset),
        .wr_en(byte_valid), .din(byte_data),   // room guaranteed by stream_control
        .rd_en(pop), .dout(fifo_dout), .empty(fifo_empty), .count(fifo_count)
    );

    stream_control #(
        .start_block(start_block),
        .fifo_depth_log2(fifo_depth_log2)
    ) u_control (
        .clk(clk), .reset(reset), .play(play),
        .reader_ready(reader_ready), .block_done(block_done),
        .fifo_count(fifo_count), .fifo_empty(fifo_empty), .period_wrap(period_wrap),
        .read_req(read_req), .block_addr(block_addr),
        .pop(pop), .load_sample(load_sample), .load_zero(load_zero)
    );

    audio_pwm u_pwm (
        .clk(clk), .reset(reset),
        .sample(fifo_dout), .load_sample(load_sample), .load_zero(load_zero),
        .period_wrap(period_wrap), .pwm_out(pwm_out)
    );

endmodule

/* source/audio_pwm.sv */
module audio_pwm (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [audio_pkg::sample_width-1:0] sample,
    input  logic                               load_sample,
    input  logic                               load_zero,
    output logic                               period_wrap,
    output logic                               pwm_out
);

    // pop at wrap, load one cycle later, so the compare runs two counts behind
    localparam logic [7:0] load_lag = 8'd2;

    logic [7:0]                         counter;
    logic [7:0]                         phase;
    logic [audio_pkg::sample_width-1:0] sample_reg;

    assign period_wrap = (counter == 8'd0);
    assign phase       = counter - load_lag;   // zero when the new sample takes effect

    always_ff @(posedge clk) begin
        if (reset) begin
            counter    <= '0;
            sample_reg <= '0;
            pwm_out    <= 1'b0;
        end else begin
            counter <= counter + 8'd1;   // free running, wraps every 256
            if (load_sample) sample_reg <= sample;
            else if (load_zero) sample_reg <= '0;
            pwm_out <= (phase < sample_reg);
        end
    end

endmodule

/* source/sample_fifo.sv */
module sample_fifo #(
    parameter int depth_log2 = 10
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_en,
    input  logic [audio_pkg::sample_width-1:0] din,
    input  logic                               rd_en,
    output logic [audio_pkg::sample_width-1:0] dout,
    output logic                               empty,
    output logic [depth_log2:0]                count
);

    logic [audio_pkg::sample_width-1:0] mem [2**depth_log2];
    logic [depth_log2-1:0]              wr_ptr;
    logic [depth_log2-1:0]              rd_ptr;
    logic                               wr_ok;
    logic                               rd_ok;

    assign empty = (count == '0);
    assign wr_ok = wr_en && !count[depth_log2];   // msb set only when full
    assign rd_ok = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];   // valid the cycle after rd_en
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/sd_block_reader.sv */
module sd_block_reader #(
    parameter int spi_div = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  read_req,
    input  logic [audio_pkg::block_addr_width-1:0] block_addr,
    output logic                                  reader_ready,
    output logic                                  byte_valid,
    output logic [audio_pkg::sample_width-1:0]    byte_data,
    output logic                                  block_done,
    output logic                                  sd_cs,
    output logic                                  sd_sclk,
    output logic                                  sd_mosi,
    input  logic                                  sd_miso
);

    localparam int cnt_width = $clog2(audio_pkg::block_bytes);

    localparam logic [3:0] s_init      = 4'd0;  // 80 clocks, cs high
    localparam logic [3:0] s_cmd0      = 4'd1;
    localparam logic [3:0] s_cmd0_resp = 4'd2;
    localparam logic [3:0] s_idle      = 4'd3;
    localparam logic [3:0] s_cmd17     = 4'd4;
    localparam logic [3:0] s_r1        = 4'd5;
    localparam logic [3:0] s_token     = 4'd6;
    localparam logic [3:0] s_data      = 4'd7;
    localparam logic [3:0] s_crc       = 4'd8;

    logic [3:0]           state;
    logic [cnt_width-1:0] cnt;        // byte index within the current step
    logic                 in_flight;  // a byte is on the wire
    logic                 xfer_start;
    logic [7:0]           tx_byte;
    logic [7:0]           next_tx;
    logic                 xfer_busy;
    logic                 xfer_done;
    logic [7:0]           rx_byte;

    spi_byte_engine #(
        .spi_div(spi_div)
    ) u_spi (
        .clk       (clk),
        .reset     (reset),
        .xfer_start(xfer_start),
        .tx_byte   (tx_byte),
        .xfer_busy (xfer_busy),
        .xfer_done (xfer_done),
        .rx_byte   (rx_byte),
        .sclk      (sd_sclk),
        .mosi      (sd_mosi),
        .miso      (sd_miso)
    );

    // block_done blocks the still-held request of the block just finished
    assign reader_ready = (state == s_idle) && !block_done;

    // command frames, everything else clocks out 0xFF
    always_comb begin
        next_tx = 8'hFF;
        case (state)
            s_cmd0: begin
                case (cnt[2:0])
                    3'd0:    next_tx = audio_pkg::cmd_go_idle;
                    3'd5:    next_tx = 8'h95;   // valid crc for CMD0
                    default: next_tx = 8'h00;
                endcase
            end
            s_cmd17: begin
                case (cnt[2:0])
                    3'd0:    next_tx = audio_pkg::cmd_read_block;
                    3'd1:    next_tx = block_addr[31:24];
                    3'd2:    next_tx = block_addr[23:16];
                    3'd3:    next_tx = block_addr[15:8];
                    3'd4:    next_tx = block_addr[7:0];
                    default: next_tx = 8'hFF;   // crc unchecked in spi mode
                endcase
            end
            default: next_tx = 8'hFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= s_init;
            cnt        <= '0;
            in_flight  <= 1'b0;
            xfer_start <= 1'b0;
            sd_cs      <= 1'b1;
            byte_valid <= 1'b0;
            block_done <= 1'b0;
        end else begin
            xfer_start <= 1'b0;
            byte_valid <= 1'b0;
            block_done <= 1'b0;
            if (state == s_idle) begin
                if (read_req && !block_done) begin
                    state <= s_cmd17;
                    cnt   <= '0;
                    sd_cs <= 1'b0;
                end
            end else if (!in_flight && !xfer_busy) begin
                xfer_start <= 1'b1;
                tx_byte    <= next_tx;
                in_flight  <= 1'b1;
            end else if (xfer_done) begin
                in_flight <= 1'b0;
                cnt       <= cnt + cnt_width'(1);
                case (state)
                    s_init: begin
                        if (cnt == cnt_width'(9)) begin
                            state <= s_cmd0;
                            cnt   <= '0;
                            sd_cs <= 1'b0;
                        end
                    end
                    s_cmd0: begin
                        if (cnt == cnt_width'(5)) begin
                            state <= s_cmd0_resp;
                        end
                    end
                    s_cmd0_resp: begin
                        if (rx_byte == audio_pkg::r1_idle) begin
                            state <= s_idle;
                            sd_cs <= 1'b1;
                        end
                    end
                    s_cmd17: begin
                        if (cnt == cnt_width'(5)) begin
                            state <= s_r1;
                        end
                    end
                    s_r1: begin
                        if (rx_byte == 8'h00) begin
                            state <= s_token;
                        end
                    end
                    s_token: begin
                        cnt <= '0;
                        if (rx_byte == audio_pkg::token_start_block) begin
                            state <= s_data;
                        end
                    end
                    s_data: begin
                        byte_valid <= 1'b1;
                        byte_data  <= rx_byte;
                        if (cnt == cnt_width'(audio_pkg::block_bytes - 1)) begin
                            state <= s_crc;
                            cnt   <= '0;
                        end
                    end
                    s_crc: begin
                        if (cnt == cnt_width'(1)) begin  // both crc bytes dropped
                            state      <= s_idle;
                            sd_cs      <= 1'b1;
                            block_done <= 1'b1;
                        end
                    end
                    default: state <= s_init;
                endcase
            end
        end
    end

endmodule

/* source/spi_byte_engine.sv */
module spi_byte_engine #(
    parameter int spi_div = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       xfer_start,
    input  logic [7:0] tx_byte,
    output logic       xfer_busy,
    output logic       xfer_done,
    output logic [7:0] rx_byte,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso
);

    localparam int div_width = (spi_div > 1) ? $clog2(spi_div) : 1;

    logic [div_width-1:0] div_cnt;   // clk cycles within one sclk half period
    logic [2:0]           bit_cnt;
    logic [7:0]           tx_shift;
    logic [7:0]           rx_shift;
    logic                 half_tick;

    assign half_tick = (div_cnt == div_width'(spi_div - 1));

    // mode 0: sample miso on the rising edge, shift mosi on the falling edge
    always_ff @(posedge clk) begin
        if (reset) begin
            xfer_busy <= 1'b0;
            xfer_done <= 1'b0;
            sclk      <= 1'b0;
            mosi      <= 1'b1;          // idle high
            div_cnt   <= '0;
            bit_cnt   <= '0;
        end else begin
            xfer_done <= 1'b0;
            if (!xfer_busy) begin
                if (xfer_start) begin
                    xfer_busy <= 1'b1;
                    tx_shift  <= tx_byte;
                    mosi      <= tx_byte[7];   // msb set up before first rise
                    div_cnt   <= '0;
                    bit_cnt   <= '0;
                end
            end else if (half_tick) begin
                div_cnt <= '0;
                if (!sclk) begin
                    sclk     <= 1'b1;
                    rx_shift <= {rx_shift[6:0], miso};
                end else begin
                    sclk <= 1'b0;
                    if (bit_cnt == 3'd7) begin
                        xfer_busy <= 1'b0;
                        xfer_done <= 1'b1;
                        rx_byte   <= rx_shift;  // last bit taken on previous rise
                        mosi      <= 1'b1;
                    end else begin
                        bit_cnt  <= bit_cnt + 3'd1;
                        tx_shift <= {tx_shift[6:0], 1'b1};
                        mosi     <= tx_shift[6];
                    end
                end
            end else begin
                div_cnt <= div_cnt + div_width'(1);
            end
        end
    end

endmodule

/* source/stream_control.sv */
module stream_control #(
    parameter logic [audio_pkg::block_addr_width-1:0] start_block = '0,
    parameter int fifo_depth_log2 = 10
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   play,
    input  logic                                   reader_ready,
    input  logic                                   block_done,
    input  logic [fifo_depth_log2:0]               fifo_count,
    input  logic                                   fifo_empty,
    input  logic                                   period_wrap,
    output logic                                   read_req,
    output logic [audio_pkg::block_addr_width-1:0] block_addr,
    output logic                                   pop,
    output logic                                   load_sample,
    output logic                                   load_zero
);

    localparam logic [fifo_depth_log2:0] fifo_depth = (fifo_depth_log2 + 1)'(1) << fifo_depth_log2;
    localparam logic [fifo_depth_log2:0] block_room =
        (fifo_depth_log2 + 1)'(audio_pkg::block_bytes);

    logic [fifo_depth_log2:0] free_space;
    logic                     has_room;

    assign free_space = fifo_depth - fifo_count;
    assign has_room   = (free_space >= block_room);   // whole block fits, no back-pressure

    assign pop = period_wrap && play && !fifo_empty;

    // block requests
    always_ff @(posedge clk) begin
        if (reset) begin
            read_req   <= 1'b0;
            block_addr <= start_block;
        end else if (block_done) begin
            read_req   <= 1'b0;
            block_addr <= block_addr + 1'b1;
        end else if (!read_req && reader_ready && has_room) begin
            read_req <= 1'b1;    // held with block_addr until block_done
        end
    end

    // sample pacing, one cycle behind the wrap to match fifo read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            load_sample <= 1'b0;
            load_zero   <= 1'b0;
        end else begin
            load_sample <= pop;
            load_zero   <= period_wrap && !pop;   // silence when paused or starved
        end
    end

endmodule

/* verification/sd_card_model.sv */
module sd_card_model (
    input  logic        cs,
    input  logic        sclk,
    input  logic        mosi,
    output logic        miso,
    output int          frame_errors,
    output logic        cmd0_answered,
    output int          cmd17_count,
    output logic [31:0] last_arg
);

    logic [31:0] rng;
    logic [7:0]  in_shift;
    logic [7:0]  out_byte;      // byte on miso during the current transfer
    logic [7:0]  frame [6];
    logic [7:0]  resp [$];      // bytes still to be clocked out
    int          bit_cnt;
    int          frame_len;
    logic        cmd0_pending;

    initial begin
        rng = 32'h1290;
        miso = 1'b1;
        in_shift = 8'h00;
        out_byte = 8'hFF;
        bit_cnt = 0;
        frame_len = 0;
        cmd0_pending = 1'b0;
        frame_errors = 0;
        cmd0_answered = 1'b0;
        cmd17_count = 0;
        last_arg = '0;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    // card content with bit 0 forced so every sample makes a pulse
    function automatic logic [7:0] lfsr_byte(input logic [31:0] byte_addr);
        logic [31:0] s;
        logic [7:0]  v;
        s = {~byte_addr[15:0] ^ byte_addr[31:16], byte_addr[15:0]} ^ 32'h1290;
        v = 8'h00;
        for (int i = 0; i < 24; i++) s = lfsr_step(s);
        for (int i = 0; i < 8; i++) begin
            s = lfsr_step(s);
            v = {v[6:0], s[0]};
        end
        return v | 8'h01;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_step(rng);
            v = (v << 1) | int'(rng[0]);
        end
        return v;
    endfunction

    task automatic push_ff(input int n);
        for (int i = 0; i < n; i++) resp.push_back(8'hFF);
    endtask

    task automatic decode_frame();
        logic [31:0] arg;
        arg = {frame[1], frame[2], frame[3], frame[4]};
        if (!frame[5][0]) begin
            frame_errors++;
            $display("card model: command frame without end bit at %0t", $time);
        end else if (frame[0] == 8'h40 && arg == 32'd0 && frame[5] == 8'h95) begin
            push_ff(1 + random_bits(3));     // ncr
            resp.push_back(8'h01);
            cmd0_pending = 1'b1;
        end else if (frame[0] == 8'h51) begin
            cmd17_count++;
            last_arg = arg;
            push_ff(1 + random_bits(3));
            resp.push_back(8'h00);
            push_ff(random_bits(4));         // access time before the token
            resp.push_back(8'hFE);
            for (int i = 0; i < audio_pkg::block_bytes; i++) begin
                resp.push_back(lfsr_byte(arg * audio_pkg::block_bytes + i));
            end
            resp.push_back(8'h5A);           // crc bytes left unchecked
            resp.push_back(8'hA5);
        end else begin
            frame_errors++;
            $display("card model: malformed command frame %h at %0t", frame[0], $time);
        end
    endtask

    task automatic take_byte(input logic [7:0] b);
        if (frame_len == 0) begin
            if (b[7:6] == 2'b01) begin
                frame[0] = b;
                frame_len = 1;
            end else if (b != 8'hFF) begin
                frame_errors++;
                $display("card model: stray byte %h outside a command at %0t", b, $time);
            end
        end else begin
            frame[frame_len] = b;
            frame_len++;
            if (frame_len == 6) begin
                decode_frame();
                frame_len = 0;
            end
        end
    endtask

    // mosi sampled on the rising edge
    always @(posedge sclk) begin
        if (!cs) begin
            in_shift = {in_shift[6:0], mosi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                take_byte(in_shift);
                out_byte = (resp.size() > 0) ? resp.pop_front() : 8'hFF;
                if (cmd0_pending && out_byte == 8'h01) begin
                    cmd0_answered = 1'b1;
                    cmd0_pending = 1'b0;
                end
            end
        end
    end

    // next miso bit shortly after the falling edge
    always @(negedge sclk) begin
        #1;
        miso = cs ? 1'b1 : out_byte[7 - bit_cnt];
    end

endmodule

/* verification/tb_audio_player.sv */
module tb_audio_player;

    localparam int first_block = 5;
    localparam int fifo_blocks = 2;        // 1024 byte fifo holds two blocks
    localparam int blocks_to_play = 3;
    localparam int fill_timeout = 100000;
    localparam int play_timeout = 3000000;
    localparam int hold_cycles = 2000;

    logic        clk;
    logic        reset;
    logic        play;
    logic        sd_miso;
    logic        sd_cs;
    logic        sd_sclk;
    logic        sd_mosi;
    logic        pwm_out;
    int          card_frame_errors;
    logic        card_cmd0_ok;
    int          card_cmd17_count;
    logic [31:0] card_last_arg;

    logic [31:0] rng;
    logic [7:0]  expected [$];   // samples in playback order
    int          next_block;
    int          played;
    int          high_len;
    int          low_run;        // negedges since play was last high
    int          seen_cmd17;
    int          errors;
    int          timeouts;

    audio_player #(
        .start_block(first_block),
        .spi_div(2)
    ) dut (
        .clk(clk), .reset(reset), .play(play), .sd_miso(sd_miso),
        .sd_cs(sd_cs), .sd_sclk(sd_sclk), .sd_mosi(sd_mosi), .pwm_out(pwm_out)
    );

    sd_card_model card (
        .cs(sd_cs), .sclk(sd_sclk), .mosi(sd_mosi), .miso(sd_miso),
        .frame_errors(card_frame_errors), .cmd0_answered(card_cmd0_ok),
        .cmd17_count(card_cmd17_count), .last_arg(card_last_arg)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // expected card content at one byte address
    function automatic logic [7:0] lfsr_byte(input logic [31:0] byte_addr);
        logic [31:0] s;
        logic [7:0]  v;
        s = {~byte_addr[15:0] ^ byte_addr[31:16], byte_addr[15:0]} ^ 32'h1290;
        v = 8'h00;
        for (int i = 0; i < 24; i++) s = lfsr_step(s);
        for (int i = 0; i < 8; i++) begin
            s = lfsr_step(s);
            v = {v[6:0], s[0]};
        end
        return v | 8'h01;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_step(rng);
            v = (v << 1) | int'(rng[0]);
        end
        return v;
    endfunction

    task automatic push_block(input int blk);
        for (int i = 0; i < audio_pkg::block_bytes; i++) begin
            expected.push_back(lfsr_byte(blk * audio_pkg::block_bytes + i));
        end
    endtask

    task automatic check_pulse(input int len);
        logic [7:0] want;
        if (expected.size() == 0) begin
            push_block(next_block);
            next_block++;
        end
        want = expected.pop_front();
        assert (len == int'(want)) else begin
            errors++;
            $display("CHECK FAILED at %0t: sample %0d pulse %0d cycles, expected %0d",
                     $time, played, len, want);
        end
        played++;
    endtask

    // pulse widths sampled mid cycle
    always @(negedge clk) begin
        if (reset) begin
            high_len = 0;
            low_run = 0;
        end else begin
            if (pwm_out) begin
                if (high_len == 0) begin
                    assert (card_cmd0_ok && low_run < 4) else begin
                        errors++;
                        $display("CHECK FAILED at %0t: pulse before init or while paused",
                                 $time);
                    end
                end
                high_len++;
            end else if (high_len > 0) begin
                check_pulse(high_len);
                high_len = 0;
            end
            low_run = play ? 0 : low_run + 1;
        end
    end

    // each block requested once and in order after CMD0
    always @(negedge clk) begin
        if (card_cmd17_count != seen_cmd17) begin
            seen_cmd17 = card_cmd17_count;
            assert (card_last_arg == 32'(first_block + seen_cmd17 - 1) && card_cmd0_ok)
            else begin
                errors++;
                $display("CHECK FAILED at %0t: CMD17 #%0d arg %0d, expected %0d",
                         $time, seen_cmd17, card_last_arg, first_block + seen_cmd17 - 1);
            end
        end
    end

    task automatic wait_for_fill();
        int cycles;
        cycles = 0;
        while (!(card_cmd17_count >= fifo_blocks && sd_cs) && cycles < fill_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!(card_cmd17_count >= fifo_blocks && sd_cs)) begin
            timeouts++;
            $display("timeout: card did not finish %0d block reads", fifo_blocks);
        end
    endtask

    task automatic hold_and_count();
        repeat (hold_cycles) @(negedge clk);
        assert (card_cmd17_count == fifo_blocks) else begin
            errors++;
            $display("CHECK FAILED at %0t: %0d block requests with play low, expected %0d",
                     $time, card_cmd17_count, fifo_blocks);
        end
    endtask

    // play toggles every 1 to 8 pwm periods
    task automatic run_play_pattern();
        int cycles;
        int left;
        cycles = 0;
        @(posedge clk);
        #1 play = 1'b1;
        left = 256 * (1 + random_bits(3));
        while (played < blocks_to_play * audio_pkg::block_bytes && cycles < play_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
            left--;
            if (left == 0) begin
                play = !play;
                left = 256 * (1 + random_bits(3));
            end
        end
        if (played < blocks_to_play * audio_pkg::block_bytes) begin
            timeouts++;
            $display("timeout: only %0d samples played", played);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d failed checks, %0d timeouts, %0d samples, %0d blocks read",
                 errors, timeouts, played, card_cmd17_count);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        play = 1'b0;
        rng = 32'h1290;
        next_block = first_block;
        played = 0;
        high_len = 0;
        low_run = 0;
        seen_cmd17 = 0;
        errors = 0;
        timeouts = 0;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        assert (sd_cs && !sd_sclk && sd_mosi && !pwm_out) else begin
            errors++;
            $display("CHECK FAILED at %0t: pins not idle after reset", $time);
        end
        wait_for_fill();              // play stays low so the fifo fills
        if (timeouts == 0) hold_and_count();
        if (timeouts == 0) run_play_pattern();
        assert (card_frame_errors == 0) else begin
            errors++;
            $display("CHECK FAILED at %0t: card saw %0d bad frames", $time, card_frame_errors);
        end
        finish_run();
    end

endmodule
